// ==== common/frontend_pkg.sv ====
/*
  Shared types and constants of the x86 instruction front end.
  The decoder handles a reduced opcode set only.
  Instruction lengths wrap above 15 bytes.
*/
`default_nettype none

package frontend_pkg;

    // Widths that carry a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [19:1] word_addr_t;
    typedef logic [3:0]  insn_len_t;
    typedef logic [1:0]  seg_t;

    // Decoder FSM states
    typedef enum logic [2:0] {
        DEC_OPCODE,
        DEC_MODRM,
        DEC_DISP_LO,
        DEC_DISP_HI,
        DEC_IMM_LO,
        DEC_IMM_HI,
        DEC_EMIT
    } dec_state_t;

    // One decoded instruction, 56 bits
    typedef struct packed {
        logic      has_seg_override;
        seg_t      segment;
        byte_t     opcode;
        logic      has_modrm;
        byte_t     modrm;
        word_t     displacement;
        word_t     immediate;
        insn_len_t length;
    } insn_t;

    // Queue depths
    localparam int PREFETCH_DEPTH   = 6;
    localparam int INSN_QUEUE_DEPTH = 4;

    // Segment override prefixes, bits 4:3 give the segment code
    localparam byte_t PREFIX_ES = 8'h26;
    localparam byte_t PREFIX_CS = 8'h2E;
    localparam byte_t PREFIX_SS = 8'h36;
    localparam byte_t PREFIX_DS = 8'h3E;

endpackage

`default_nettype wire

// ==== common/byte_stream_if.sv ====
/*
  Prefetched byte stream between the prefetch FIFO and the decoder.
  A byte moves on a clock edge with valid and ready both high.
  flush discards all in-flight state on both sides in that cycle.
*/
`timescale 1ns/1ns
`default_nettype none

interface byte_stream_if;
    import frontend_pkg::*;

    byte_t data;
    logic  valid;
    logic  ready;
    logic  flush;

    // FIFO side, flush comes from the redirect
    modport source (
        output data,
        output valid,
        output flush,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  flush,
        output ready
    );

endinterface

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
/*
  Synchronous first-word-fall-through FIFO with flush.
  Any depth of 2 or more, not limited to powers of two.
  Writes when full and reads when empty are ignored; flush wins over both.
*/
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             wr_en,
    input  logic [width-1:0] wr_data,
    input  logic             rd_en,
    output logic [width-1:0] rd_data,
    output logic             empty,
    output logic             room2,
    output logic             full
);

    logic [width-1:0]           mem [depth];
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth+1)-1:0] count;
    logic                       do_wr;
    logic                       do_rd;

    function automatic logic [$clog2(depth)-1:0] next_ptr(
        input logic [$clog2(depth)-1:0] p
    );
        if (p == depth - 1) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign empty = (count == 0);
    assign full  = (count == depth);
    assign room2 = (count + 2 <= depth);

    assign do_wr = wr_en && !full && !flush;
    assign do_rd = rd_en && !empty && !flush;

    // Head entry visible without a read
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== prefetch/fetch_unit.sv ====
/*
  Instruction bus master. Fetches 16-bit words from CS*16+IP onwards
  and streams their bytes, low byte first, into the prefetch FIFO.
  Idle after reset until the first load_ip.
  A new access starts only with the holding register empty and room
  for two bytes in the FIFO. An access cut off by a redirect still
  completes on the bus, but its data is dropped.
*/
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_ip,
    input  frontend_pkg::word_t      new_cs,
    input  frontend_pkg::word_t      new_ip,
    output frontend_pkg::word_addr_t mem_addr,
    input  frontend_pkg::word_t      mem_data,
    output logic                     mem_access,
    input  logic                     mem_ack,
    output logic                     byte_wr_en,
    output frontend_pkg::byte_t      byte_wr_data,
    input  logic                     fifo_room
);
    import frontend_pkg::*;

    logic [19:0] new_phys;
    word_addr_t  word_addr;
    logic        skip_low;
    logic        acc_skip;
    logic        active;
    logic        discard;
    word_t       hold;
    logic        hold_lo_v;
    logic        hold_hi_v;
    logic        start;
    logic        keep_data;

    // 20-bit physical address wraps at 1 MiB
    assign new_phys = {new_cs, 4'h0} + {4'h0, new_ip};

    assign start = active && !mem_access && !hold_lo_v && !hold_hi_v &&
                   fifo_room && !load_ip;

    // Ack data is kept unless a redirect cut the access off
    assign keep_data = mem_access && mem_ack && !discard && !load_ip;

    assign byte_wr_en   = hold_lo_v || hold_hi_v;
    assign byte_wr_data = hold_lo_v ? hold[7:0] : hold[15:8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_addr  <= '0;
            skip_low   <= 1'b0;
            acc_skip   <= 1'b0;
            active     <= 1'b0;
            discard    <= 1'b0;
            mem_access <= 1'b0;
            mem_addr   <= '0;
            hold_lo_v  <= 1'b0;
            hold_hi_v  <= 1'b0;
        end else begin
            // Next word to fetch
            if (load_ip) begin
                word_addr <= new_phys[19:1];
                skip_low  <= new_phys[0];
                active    <= 1'b1;
            end else if (start) begin
                word_addr <= word_addr + 1'b1;
                skip_low  <= 1'b0;
            end

            // Bus handshake, address held until ack
            if (start) begin
                mem_access <= 1'b1;
                mem_addr   <= word_addr;
                acc_skip   <= skip_low;
            end else if (mem_access && mem_ack) begin
                mem_access <= 1'b0;
            end

            if (load_ip && mem_access && !mem_ack) begin
                discard <= 1'b1;
            end else if (mem_access && mem_ack) begin
                discard <= 1'b0;
            end

            // Byte drain, one per cycle
            if (load_ip) begin
                hold_lo_v <= 1'b0;
                hold_hi_v <= 1'b0;
            end else if (keep_data) begin
                hold_lo_v <= !acc_skip;
                hold_hi_v <= 1'b1;
            end else if (hold_lo_v) begin
                hold_lo_v <= 1'b0;
            end else if (hold_hi_v) begin
                hold_hi_v <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keep_data) begin
            hold <= mem_data;
        end
    end

endmodule

`default_nettype wire

// ==== decode/insn_decoder.sv ====
/*
  Byte-serial instruction decoder for a reduced 8086 opcode set.
  Takes at most one byte per cycle and writes the record in DEC_EMIT,
  the cycle after the last byte. A full queue holds it in DEC_EMIT.
  Only one segment prefix is kept; a later prefix replaces it but
  still counts towards the length.
*/
`timescale 1ns/1ns
`default_nettype none

module insn_decoder (
    input  logic                clk,
    input  logic                rst_n,
    byte_stream_if.sink         bytes,
    output logic                insn_wr_en,
    output frontend_pkg::insn_t insn,
    input  logic                queue_full
);
    import frontend_pkg::*;

    dec_state_t state;
    insn_t      rec;
    logic       has_imm;
    logic       imm16;
    logic       disp8;
    logic       take;
    logic       op_prefix;
    logic       op_modrm;
    logic       op_imm;
    logic       op_imm16;
    logic [1:0] mod_field;
    logic       mod_disp16;

    // State after the ModRM and displacement fields
    function automatic dec_state_t after_disp(input logic imm);
        return imm ? DEC_IMM_LO : DEC_EMIT;
    endfunction

    assign bytes.ready = (state != DEC_EMIT);
    assign take        = bytes.valid && bytes.ready;
    assign insn_wr_en  = (state == DEC_EMIT) && !queue_full;
    assign insn        = rec;

    assign mod_field  = bytes.data[7:6];
    assign mod_disp16 = (mod_field == 2'b10) ||
                        (mod_field == 2'b00 && bytes.data[2:0] == 3'b110);

    // Opcode classification of the head byte
    always_comb begin
        op_prefix = (bytes.data == PREFIX_ES) || (bytes.data == PREFIX_CS) ||
                    (bytes.data == PREFIX_SS) || (bytes.data == PREFIX_DS);
        op_modrm  = 1'b0;
        op_imm    = 1'b0;
        op_imm16  = 1'b0;
        if (bytes.data[7:6] == 2'b00 && !op_prefix) begin
            // ALU group, low three bits select the form
            case (bytes.data[2:0])
                3'd0, 3'd1, 3'd2, 3'd3: op_modrm = 1'b1;
                3'd4: op_imm = 1'b1;
                3'd5: begin
                    op_imm   = 1'b1;
                    op_imm16 = 1'b1;
                end
                default: ;
            endcase
        end
        case (bytes.data) inside
            [8'h88:8'h8B]: op_modrm = 1'b1;
            8'h80, 8'hC6: begin
                op_modrm = 1'b1;
                op_imm   = 1'b1;
            end
            8'h81, 8'hC7: begin
                op_modrm = 1'b1;
                op_imm   = 1'b1;
                op_imm16 = 1'b1;
            end
            [8'hB0:8'hB7]: op_imm = 1'b1;
            [8'hB8:8'hBF]: begin
                op_imm   = 1'b1;
                op_imm16 = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= DEC_OPCODE;
            rec     <= '0;
            has_imm <= 1'b0;
            imm16   <= 1'b0;
            disp8   <= 1'b0;
        end else if (bytes.flush) begin
            state   <= DEC_OPCODE;
            rec     <= '0;
            has_imm <= 1'b0;
            imm16   <= 1'b0;
            disp8   <= 1'b0;
        end else begin
            case (state)
                DEC_OPCODE: if (take) begin
                    rec.length <= rec.length + 1'b1;
                    if (op_prefix) begin
                        rec.has_seg_override <= 1'b1;
                        rec.segment          <= bytes.data[4:3];
                    end else begin
                        rec.opcode    <= bytes.data;
                        rec.has_modrm <= op_modrm;
                        has_imm       <= op_imm;
                        imm16         <= op_imm16;
                        state         <= op_modrm ? DEC_MODRM : after_disp(op_imm);
                    end
                end
                DEC_MODRM: if (take) begin
                    rec.modrm  <= bytes.data;
                    rec.length <= rec.length + 1'b1;
                    disp8      <= (mod_field == 2'b01);
                    if (mod_field == 2'b01 || mod_disp16) begin
                        state <= DEC_DISP_LO;
                    end else begin
                        state <= after_disp(has_imm);
                    end
                end
                DEC_DISP_LO: if (take) begin
                    rec.length <= rec.length + 1'b1;
                    if (disp8) begin
                        rec.displacement <= {{8{bytes.data[7]}}, bytes.data};
                        state            <= after_disp(has_imm);
                    end else begin
                        rec.displacement[7:0] <= bytes.data;
                        state                 <= DEC_DISP_HI;
                    end
                end
                DEC_DISP_HI: if (take) begin
                    rec.displacement[15:8] <= bytes.data;
                    rec.length             <= rec.length + 1'b1;
                    state                  <= after_disp(has_imm);
                end
                DEC_IMM_LO: if (take) begin
                    rec.immediate <= {8'h00, bytes.data};
                    rec.length    <= rec.length + 1'b1;
                    state         <= imm16 ? DEC_IMM_HI : DEC_EMIT;
                end
                DEC_IMM_HI: if (take) begin
                    rec.immediate[15:8] <= bytes.data;
                    rec.length          <= rec.length + 1'b1;
                    state               <= DEC_EMIT;
                end
                DEC_EMIT: if (insn_wr_en) begin
                    // Fresh record, absent fields read as zero
                    rec   <= '0;
                    state <= DEC_OPCODE;
                end
                default: state <= DEC_OPCODE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/x86_frontend.sv ====
/*
  x86 instruction front end: fetch, prefetch FIFO, decoder and
  instruction queue. Nothing is fetched before the first load_ip.
  load_ip flushes both FIFOs and the decoder in the same cycle.
  Record fields hold while insn_valid is high and insn_ready low.
*/
`timescale 1ns/1ns
`default_nettype none

module x86_frontend (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_ip,
    input  frontend_pkg::word_t      new_cs,
    input  frontend_pkg::word_t      new_ip,
    output frontend_pkg::word_addr_t instr_m_addr,
    input  frontend_pkg::word_t      instr_m_data_in,
    output logic                     instr_m_access,
    input  logic                     instr_m_ack,
    output logic                     insn_valid,
    input  logic                     insn_ready,
    output frontend_pkg::byte_t      insn_opcode,
    output frontend_pkg::byte_t      insn_modrm,
    output logic                     insn_has_modrm,
    output frontend_pkg::word_t      insn_displacement,
    output frontend_pkg::word_t      insn_immediate,
    output frontend_pkg::insn_len_t  insn_length,
    output logic                     insn_has_seg_override,
    output frontend_pkg::seg_t       insn_segment
);
    import frontend_pkg::*;

    logic  pf_wr_en;
    byte_t pf_wr_data;
    logic  pf_room2;
    logic  pf_empty;
    logic  dec_wr_en;
    insn_t dec_insn;
    logic  q_full;
    logic  q_empty;
    insn_t q_insn;

    byte_stream_if u_byte_stream ();

    assign u_byte_stream.valid = !pf_empty;
    assign u_byte_stream.flush = load_ip;

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_ip      (load_ip),
        .new_cs       (new_cs),
        .new_ip       (new_ip),
        .mem_addr     (instr_m_addr),
        .mem_data     (instr_m_data_in),
        .mem_access   (instr_m_access),
        .mem_ack      (instr_m_ack),
        .byte_wr_en   (pf_wr_en),
        .byte_wr_data (pf_wr_data),
        .fifo_room    (pf_room2)
    );

    sync_fifo #(
        .width ($bits(byte_t)),
        .depth (PREFETCH_DEPTH)
    ) u_prefetch_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (load_ip),
        .wr_en   (pf_wr_en),
        .wr_data (pf_wr_data),
        .rd_en   (u_byte_stream.valid && u_byte_stream.ready),
        .rd_data (u_byte_stream.data),
        .empty   (pf_empty),
        .room2   (pf_room2),
        .full    ()
    );

    insn_decoder u_insn_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .bytes      (u_byte_stream.sink),
        .insn_wr_en (dec_wr_en),
        .insn       (dec_insn),
        .queue_full (q_full)
    );

    sync_fifo #(
        .width ($bits(insn_t)),
        .depth (INSN_QUEUE_DEPTH)
    ) u_insn_queue (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (load_ip),
        .wr_en   (dec_wr_en),
        .wr_data (dec_insn),
        .rd_en   (insn_ready),
        .rd_data (q_insn),
        .empty   (q_empty),
        .room2   (),
        .full    (q_full)
    );

    // Output port, fields straight from the queue head
    assign insn_valid            = !q_empty;
    assign insn_opcode           = q_insn.opcode;
    assign insn_modrm            = q_insn.modrm;
    assign insn_has_modrm        = q_insn.has_modrm;
    assign insn_displacement     = q_insn.displacement;
    assign insn_immediate        = q_insn.immediate;
    assign insn_length           = q_insn.length;
    assign insn_has_seg_override = q_insn.has_seg_override;
    assign insn_segment          = q_insn.segment;

endmodule

`default_nettype wire

// ==== sim/frontend_props.sv ====
/*
  Concurrent checks on the front end, bound to x86_frontend.
  Covers the instruction bus hold rule, stable output records
  under back-pressure and quiet outputs during reset.
*/
`timescale 1ns/1ns
`default_nettype none

module frontend_props (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     load_ip,
    input frontend_pkg::word_addr_t instr_m_addr,
    input logic                     instr_m_access,
    input logic                     instr_m_ack,
    input logic                     insn_valid,
    input logic                     insn_ready,
    input frontend_pkg::byte_t      insn_opcode,
    input frontend_pkg::byte_t      insn_modrm,
    input logic                     insn_has_modrm,
    input frontend_pkg::word_t      insn_displacement,
    input frontend_pkg::word_t      insn_immediate,
    input frontend_pkg::insn_len_t  insn_length,
    input logic                     insn_has_seg_override,
    input frontend_pkg::seg_t       insn_segment
);

    logic [55:0] fields;

    assign fields = {insn_has_seg_override, insn_segment, insn_opcode, insn_has_modrm,
                     insn_modrm, insn_displacement, insn_immediate, insn_length};

    // Access and address stay put until the ack arrives
    assert property (@(posedge clk) disable iff (!rst_n)
        instr_m_access && !instr_m_ack |=> instr_m_access && $stable(instr_m_addr))
        else $error("instruction bus access dropped or moved before ack");

    // Head record holds while the consumer stalls, unless a redirect flushes it
    assert property (@(posedge clk) disable iff (!rst_n)
        insn_valid && !insn_ready && !load_ip |=> insn_valid && $stable(fields))
        else $error("output record changed while stalled");

    assert property (@(posedge clk)
        !rst_n |=> !insn_valid && !instr_m_access)
        else $error("valid or bus access seen during reset");

endmodule

`default_nettype wire

// ==== sim/tb_x86_frontend.sv ====
/*
  Directed tests of the x86 front end.
  A 64 KiB byte memory answers the instruction bus after 0 to 3 cycles.
  Expected records come from a reference decoder over the memory image.
  Physical addresses used by the tests stay below 64 KiB.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_x86_frontend;
    import frontend_pkg::*;

    localparam int CLK_HALF     = 2;
    localparam int POP_TIMEOUT  = 200;
    // Watchdog budget is records times worst cycles per record times a margin
    localparam int TOTAL_INSNS  = 72;
    localparam int INSN_CYCLES  = 60;
    localparam int WATCHDOG_NS  = TOTAL_INSNS * INSN_CYCLES * 4 * 2 * CLK_HALF;

    logic       clk;
    logic       rst_n;
    logic       load_ip;
    word_t      new_cs;
    word_t      new_ip;
    word_addr_t instr_m_addr;
    word_t      instr_m_data_in = '0;
    logic       instr_m_access;
    logic       instr_m_ack = 1'b0;
    logic       insn_valid;
    logic       insn_ready;
    byte_t      insn_opcode;
    byte_t      insn_modrm;
    logic       insn_has_modrm;
    word_t      insn_displacement;
    word_t      insn_immediate;
    insn_len_t  insn_length;
    logic       insn_has_seg_override;
    seg_t       insn_segment;

    byte_t  mem [65536];
    insn_t  exp_q [$];
    integer seed = 4544;
    int     checks = 0;
    int     errors = 0;
    int     ack_delay = 0;
    logic   ack_busy = 1'b0;

    x86_frontend u_x86_frontend (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .load_ip               (load_ip),
        .new_cs                (new_cs),
        .new_ip                (new_ip),
        .instr_m_addr          (instr_m_addr),
        .instr_m_data_in       (instr_m_data_in),
        .instr_m_access        (instr_m_access),
        .instr_m_ack           (instr_m_ack),
        .insn_valid            (insn_valid),
        .insn_ready            (insn_ready),
        .insn_opcode           (insn_opcode),
        .insn_modrm            (insn_modrm),
        .insn_has_modrm        (insn_has_modrm),
        .insn_displacement     (insn_displacement),
        .insn_immediate        (insn_immediate),
        .insn_length           (insn_length),
        .insn_has_seg_override (insn_has_seg_override),
        .insn_segment          (insn_segment)
    );

    bind x86_frontend frontend_props u_frontend_props (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .load_ip               (load_ip),
        .instr_m_addr          (instr_m_addr),
        .instr_m_access        (instr_m_access),
        .instr_m_ack           (instr_m_ack),
        .insn_valid            (insn_valid),
        .insn_ready            (insn_ready),
        .insn_opcode           (insn_opcode),
        .insn_modrm            (insn_modrm),
        .insn_has_modrm        (insn_has_modrm),
        .insn_displacement     (insn_displacement),
        .insn_immediate        (insn_immediate),
        .insn_length           (insn_length),
        .insn_has_seg_override (insn_has_seg_override),
        .insn_segment          (insn_segment)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Memory model acks one to four falling edges after access rises
    always @(negedge clk) begin
        if (!rst_n) begin
            instr_m_ack = 1'b0;
            ack_busy    = 1'b0;
        end else if (instr_m_ack) begin
            instr_m_ack = 1'b0;
        end else if (instr_m_access) begin
            if (!ack_busy) begin
                ack_delay = {$random(seed)} % 4;
                ack_busy  = 1'b1;
            end
            if (ack_delay == 0) begin
                instr_m_data_in = {mem[{instr_m_addr[15:1], 1'b1}],
                                   mem[{instr_m_addr[15:1], 1'b0}]};
                instr_m_ack     = 1'b1;
                ack_busy        = 1'b0;
            end else begin
                ack_delay--;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic is_prefix(input byte_t b);
        return b == PREFIX_ES || b == PREFIX_CS || b == PREFIX_SS || b == PREFIX_DS;
    endfunction

    function automatic seg_t prefix_segment(input byte_t b);
        case (b)
            PREFIX_ES: return 2'd0;
            PREFIX_CS: return 2'd1;
            PREFIX_SS: return 2'd2;
            default:   return 2'd3;
        endcase
    endfunction

    // ModRM and immediate size of a non-prefix opcode
    function automatic void op_form(input byte_t op, output logic modrm, output int imm_bytes);
        modrm     = 1'b0;
        imm_bytes = 0;
        if (op <= 8'h3F) begin
            if (op[2:0] <= 3'd3) begin
                modrm = 1'b1;
            end else if (op[2:0] == 3'd4) begin
                imm_bytes = 1;
            end else if (op[2:0] == 3'd5) begin
                imm_bytes = 2;
            end
        end else if (op >= 8'h88 && op <= 8'h8B) begin
            modrm = 1'b1;
        end else if (op == 8'h80 || op == 8'hC6 || op == 8'h81 || op == 8'hC7) begin
            modrm     = 1'b1;
            imm_bytes = (op[0] == 1'b1) ? 2 : 1;
        end else if (op >= 8'hB0 && op <= 8'hBF) begin
            imm_bytes = (op[3] == 1'b1) ? 2 : 1;
        end
    endfunction

    // Expected record for the instruction at a physical address
    function automatic insn_t ref_decode(input logic [15:0] pa);
        insn_t       r;
        logic [15:0] p;
        byte_t       op;
        logic        modrm;
        int          imm_bytes;
        r  = '0;
        p  = pa;
        op = mem[p];
        while (is_prefix(op)) begin
            r.has_seg_override = 1'b1;
            r.segment          = prefix_segment(op);
            p                  = p + 16'd1;
            op                 = mem[p];
        end
        r.opcode = op;
        p        = p + 16'd1;
        op_form(op, modrm, imm_bytes);
        r.has_modrm = modrm;
        if (modrm) begin
            r.modrm = mem[p];
            p       = p + 16'd1;
            if (r.modrm[7:6] == 2'b01) begin
                r.displacement = {{8{mem[p][7]}}, mem[p]};
                p              = p + 16'd1;
            end else if (r.modrm[7:6] == 2'b10 ||
                         (r.modrm[7:6] == 2'b00 && r.modrm[2:0] == 3'b110)) begin
                r.displacement = {mem[p + 16'd1], mem[p]};
                p              = p + 16'd2;
            end
        end
        if (imm_bytes == 1) begin
            r.immediate = {8'h00, mem[p]};
            p           = p + 16'd1;
        end else if (imm_bytes == 2) begin
            r.immediate = {mem[p + 16'd1], mem[p]};
            p           = p + 16'd2;
        end
        r.length = insn_len_t'(p - pa);
        return r;
    endfunction

    task automatic compare(input logic [15:0] got, input logic [15:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Stores the last n bytes of stream at addr, most significant first
    task automatic place(input logic [15:0] addr, input logic [255:0] stream, input int n);
        for (int i = 0; i < n; i++) begin
            mem[addr + 16'(i)] = byte_t'(stream >> (8 * (n - 1 - i)));
        end
    endtask

    task automatic redirect(input word_t cs, input word_t ip);
        new_cs  = cs;
        new_ip  = ip;
        load_ip = 1'b1;
        @(negedge clk);
        load_ip = 1'b0;
    endtask

    // Pops n records and checks them against the reference from start
    task automatic run_stream(input logic [15:0] start, input int n, input logic rand_ready,
                              input string name);
        insn_t       exp;
        logic [15:0] pa;
        int          waited;
        int          gap;
        string       tag;
        pa = start;
        for (int i = 0; i < n; i++) begin
            exp = ref_decode(pa);
            exp_q.push_back(exp);
            pa = pa + {12'h000, exp.length};
        end
        for (int i = 0; i < n; i++) begin
            gap = rand_ready ? {$random(seed)} % 4 : 0;
            repeat (gap) @(negedge clk);
            waited = 0;
            while (!insn_valid && waited < POP_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!insn_valid) begin
                errors++;
                $display("Error at %0t ns: %s got no record %0d from the DUT", $time, name, i);
                exp_q.delete();
                return;
            end
            exp = exp_q.pop_front();
            tag = $sformatf("%s #%0d", name, i);
            compare(16'(insn_opcode), 16'(exp.opcode), {tag, " opcode"});
            compare(16'(insn_has_modrm), 16'(exp.has_modrm), {tag, " has_modrm"});
            compare(16'(insn_modrm), 16'(exp.modrm), {tag, " modrm"});
            compare(insn_displacement, exp.displacement, {tag, " displacement"});
            compare(insn_immediate, exp.immediate, {tag, " immediate"});
            compare(16'(insn_length), 16'(exp.length), {tag, " length"});
            compare(16'(insn_has_seg_override), 16'(exp.has_seg_override),
                    {tag, " has_seg_override"});
            compare(16'(insn_segment), 16'(exp.segment), {tag, " segment"});
            insn_ready = 1'b1;
            @(negedge clk);
            insn_ready = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        $display("%-14s %s, %0d errors", name,
                 (errors == errs_before) ? "ok" : "failed", errors - errs_before);
    endtask

    task automatic load_images();
        logic [15:0] a;
        for (int i = 0; i < 65536; i++) begin
            a      = 16'(i);
            mem[a] = a[7:0] ^ a[15:8];
        end
        place(16'h0100, 256'h90_40_41_42_43_F4_C3_9C, 8);
        // none, disp8 negative, disp16, mod 00 rm 110, mod 00 plain
        place(16'h0200, 256'h01D8_8B46FC_89873412_03067856_8807, 15);
        place(16'h0300, 256'h04F0_053412_B39A_BACDAB_80C1FF_8146021122_C606001055_C7C07856,
              27);
        // ES, CS, SS, DS, then ES replaced by DS
        place(16'h0400, 256'h268B07_2E90_36B80102_3E894610_263E90, 16);
        place(16'h0500, 256'h8B46FC_90_B83412_050001_8807_9090_B0AA, 16);
        // 0xB8 at the even byte catches a missed low-byte skip
        place(16'h0604, 256'hB8_B93412_3E8B46F8_90_047F, 11);
        for (int i = 0; i < 512; i++) begin
            mem[16'h1000 + 16'(i)] = byte_t'($random(seed));
        end
    endtask

    task automatic test_one_byte();
        int e;
        e = errors;
        redirect(16'h0000, 16'h0100);
        run_stream(16'h0100, 8, 1'b0, "one_byte");
        finish_test("one_byte", e);
    endtask

    task automatic test_modrm_disp();
        int e;
        e = errors;
        redirect(16'h0000, 16'h0200);
        run_stream(16'h0200, 5, 1'b0, "modrm_disp");
        finish_test("modrm_disp", e);
    endtask

    task automatic test_immediates();
        int e;
        e = errors;
        redirect(16'h0000, 16'h0300);
        run_stream(16'h0300, 8, 1'b0, "immediates");
        finish_test("immediates", e);
    endtask

    task automatic test_prefixes();
        int e;
        e = errors;
        redirect(16'h0030, 16'h0100);
        run_stream(16'h0400, 5, 1'b0, "prefixes");
        finish_test("prefixes", e);
    endtask

    task automatic test_random_stream();
        int e;
        e = errors;
        redirect(16'h0100, 16'h0000);
        run_stream(16'h1000, 40, 1'b1, "random_stream");
        finish_test("random_stream", e);
    endtask

    task automatic test_redirect_odd();
        int e;
        e = errors;
        redirect(16'h0000, 16'h0500);
        run_stream(16'h0500, 2, 1'b0, "before_jump");
        // Cut in while the rest of the old stream is still in flight
        redirect(16'h0060, 16'h0005);
        run_stream(16'h0605, 4, 1'b0, "after_jump");
        finish_test("redirect_odd", e);
    endtask

    initial begin
        rst_n      = 1'b0;
        load_ip    = 1'b0;
        new_cs     = '0;
        new_ip     = '0;
        insn_ready = 1'b0;
        load_images();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Nothing happens before the first redirect
        repeat (4) @(negedge clk);
        compare(16'(instr_m_access), 16'd0, "idle access");
        compare(16'(insn_valid), 16'd0, "idle insn_valid");
        finish_test("idle_reset", 0);

        test_one_byte();
        test_modrm_disp();
        test_immediates();
        test_prefixes();
        test_random_stream();
        test_redirect_odd();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== x86_frontend.f ====
common/frontend_pkg.sv
common/byte_stream_if.sv
verilog/sync_fifo.sv
prefetch/fetch_unit.sv
decode/insn_decoder.sv
verilog/x86_frontend.sv
sim/frontend_props.sv
sim/tb_x86_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       ?= tb_x86_frontend
FILELIST  ?= x86_frontend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "STATUS: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
